// File: src/joy_frame_pkg.sv
package joy_frame_pkg;

  ////////////////////
  // Frame geometry
  ////////////////////
  localparam int FRAME_SLOTS       = 26;  // ena_x cycles per frame
  localparam int FIRST_SAMPLE_SLOT = 2;   // Slot 0 loads, slot 1 is dead time
  localparam int SAMPLE_SLOTS      = FRAME_SLOTS - FIRST_SAMPLE_SLOT;
  localparam int SLOT_W            = $clog2(FRAME_SLOTS);

  ////////////////////
  // Pad word layout
  ////////////////////
  // One pad, every field active low
  typedef struct packed {
    logic       reset_n;  // Bit 11, arcade reset / reboot button
    logic       aux_b;    // Bit 10
    logic       coin_n;   // Bit 9
    logic       start_n;  // Bit 8
    logic       aux_a;    // Bit 7
    logic [6:0] action;   // Bits 6:0, low six are directions and fire
  } pad_t;

  // Result of one frame, both pads
  typedef struct packed {
    pad_t pad_a;  // Bits 23:12
    pad_t pad_b;  // Bits 11:0
  } snapshot_t;

  localparam int SNAP_W    = $bits(snapshot_t);
  localparam int BIT_IDX_W = $clog2(SNAP_W);

  typedef enum logic [1:0] {
    IDLE,   // Out of reset, before the first load
    LOAD,   // Slot 0, parallel load of the pads
    SHIFT   // Slots 1 to 25
  } reader_state_e;

  // Snapshot bit written in each sampled slot, slot 2 first
  // Pad A sits 12 bits above pad B
  localparam logic [BIT_IDX_W-1:0] SLOT_BIT [SAMPLE_SLOTS] = '{
    5'd20, 5'd18, 5'd17, 5'd16, 5'd15, 5'd14, 5'd13, 5'd12,  // A 8,6..0
    5'd8,  5'd6,  5'd5,  5'd4,  5'd3,  5'd2,  5'd1,  5'd0,   // B 8,6..0
    5'd10, 5'd11, 5'd9,  5'd7,                               // B 10,11,9,7
    5'd22, 5'd23, 5'd21, 5'd19                               // A 10,11,9,7
  };

endpackage

// File: src/game_ctrl_pkg.sv
package game_ctrl_pkg;

  ////////////////////
  // Snapshot buffer
  ////////////////////
  localparam int FIFO_DEPTH = 4;                    // Entries, also credits
  localparam int CREDIT_W   = 3;                    // Holds 0..FIFO_DEPTH
  localparam int PTR_W      = $clog2(FIFO_DEPTH);   // Read/write pointer

  ////////////////////
  // Game-side inputs
  ////////////////////
  // Everything active high, as the game core expects after inversion
  typedef struct packed {
    logic [5:0] joystick_a;  // Player 1 directions and fire
    logic [5:0] joystick_b;  // Player 2 directions and fire
    logic [1:0] coin;        // [1] pad B, [0] pad A
    logic [1:0] start;       // [1] pad B, [0] pad A
    logic       aux_a;       // Player 1 second button
    logic       aux_b;       // Player 2 second button
  } game_inputs_t;

endpackage

// File: src/joy_frame_reader.sv
module joy_frame_reader (
  input  logic                   ena_x,
  input  logic                   pll_lckd,
  input  logic                   joy_data,       // Serial data from the chained pads
  output logic                   joy_load,       // Low loads the pads
  input  logic                   credit_return,  // One entry left the buffer
  output logic                   snap_valid,
  output joy_frame_pkg::snapshot_t snap
);

  joy_frame_pkg::reader_state_e          state;
  logic [joy_frame_pkg::SLOT_W-1:0]      slot_cnt;
  logic [joy_frame_pkg::SLOT_W-1:0]      sample_idx;
  logic [joy_frame_pkg::SNAP_W-1:0]      shift_word;  // Bits land here in slot order
  logic                                  frame_done;  // Word complete this cycle
  logic                                  first_frame;
  logic                                  changed;
  joy_frame_pkg::snapshot_t              ref_word;    // Newest word taken, sent or pending
  joy_frame_pkg::snapshot_t              pend_word;
  logic                                  pend_valid;
  logic [game_ctrl_pkg::CREDIT_W-1:0]    credit_cnt;
  logic                                  send_now;

  assign joy_load   = (state != joy_frame_pkg::LOAD);  // Low in slot 0 only
  assign sample_idx = slot_cnt - joy_frame_pkg::SLOT_W'(joy_frame_pkg::FIRST_SAMPLE_SLOT);
  assign changed    = first_frame || (shift_word != joy_frame_pkg::SNAP_W'(ref_word));
  assign send_now   = pend_valid && (credit_cnt != '0);

  ////////////////////
  // Frame sequencer
  ////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      state      <= joy_frame_pkg::IDLE;
      slot_cnt   <= '0;
      frame_done <= 1'b0;
    end else begin
      frame_done <= 1'b0;
      unique case (state)
        joy_frame_pkg::IDLE: state <= joy_frame_pkg::LOAD;
        joy_frame_pkg::LOAD: begin
          state    <= joy_frame_pkg::SHIFT;
          slot_cnt <= joy_frame_pkg::SLOT_W'(1);
        end
        joy_frame_pkg::SHIFT: begin
          if (slot_cnt == joy_frame_pkg::SLOT_W'(joy_frame_pkg::FRAME_SLOTS - 1)) begin
            state      <= joy_frame_pkg::LOAD;  // Wrap to the next load
            slot_cnt   <= '0;
            frame_done <= 1'b1;                 // Last bit taken on this edge
          end else begin
            slot_cnt <= slot_cnt + 1'b1;
          end
        end
        default: state <= joy_frame_pkg::IDLE;
      endcase
    end
  end

  // Scatter each sampled bit by the slot table
  always_ff @(posedge ena_x) begin
    if (state == joy_frame_pkg::SHIFT &&
        slot_cnt >= joy_frame_pkg::SLOT_W'(joy_frame_pkg::FIRST_SAMPLE_SLOT)) begin
      shift_word[joy_frame_pkg::SLOT_BIT[sample_idx]] <= joy_data;
    end
  end

  ////////////////////
  // Change filter and credits
  ////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      first_frame <= 1'b1;
      pend_valid  <= 1'b0;
      snap_valid  <= 1'b0;
      credit_cnt  <= game_ctrl_pkg::CREDIT_W'(game_ctrl_pkg::FIFO_DEPTH);
    end else begin
      snap_valid <= send_now;
      if (frame_done && changed) begin
        first_frame <= 1'b0;
        pend_valid  <= 1'b1;  // Latest wins over an unsent word
      end else if (send_now) begin
        pend_valid <= 1'b0;
      end
      unique case ({send_now, credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;  // None or both
      endcase
    end
  end

  always_ff @(posedge ena_x) begin
    if (send_now) snap <= pend_word;  // Old pending goes out first
    if (frame_done && changed) begin
      pend_word <= joy_frame_pkg::snapshot_t'(shift_word);
      ref_word  <= joy_frame_pkg::snapshot_t'(shift_word);
    end
  end

  a_credit_bound: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    credit_cnt <= game_ctrl_pkg::CREDIT_W'(game_ctrl_pkg::FIFO_DEPTH));

  // A send always spends a credit held in the cycle before
  a_send_credit: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    $rose(snap_valid) |-> $past(credit_cnt) != '0);

endmodule

// File: src/snapshot_fifo.sv
module snapshot_fifo (
  input  logic                     ena_x,
  input  logic                     pll_lckd,
  input  logic                     snap_valid,     // Write, never refused
  input  joy_frame_pkg::snapshot_t snap,
  input  logic                     pop,            // Advance head
  output logic                     fifo_nonempty,
  output joy_frame_pkg::snapshot_t head,
  output logic                     credit_return   // One cycle after a pop
);

  joy_frame_pkg::snapshot_t            mem [game_ctrl_pkg::FIFO_DEPTH];
  logic [game_ctrl_pkg::PTR_W-1:0]     wr_ptr;
  logic [game_ctrl_pkg::PTR_W-1:0]     rd_ptr;
  logic [game_ctrl_pkg::CREDIT_W-1:0]  count;     // Occupancy
  logic                                full;

  assign full          = (count == game_ctrl_pkg::CREDIT_W'(game_ctrl_pkg::FIFO_DEPTH));
  assign fifo_nonempty = (count != '0);
  assign head          = mem[rd_ptr];  // Oldest entry

  ////////////////////
  // Pointers
  ////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      credit_return <= 1'b0;
    end else begin
      credit_return <= pop;  // Slot freed, hand the credit back
      if (snap_valid) wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
      if (pop)        rd_ptr <= rd_ptr + 1'b1;
      unique case ({snap_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Storage
  always_ff @(posedge ena_x) begin
    if (snap_valid) mem[wr_ptr] <= snap;
  end

  // Credits upstream must keep the store from overflowing
  a_no_write_full: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    snap_valid |-> !full);

  // Mapper only pops what it saw present
  a_no_pop_empty: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    pop |-> fifo_nonempty);

endmodule

// File: src/game_input_mapper.sv
module game_input_mapper (
  input  logic                        ena_x,
  input  logic                        pll_lckd,
  input  logic                        game_tick,      // Game input-sample strobe
  input  logic                        fifo_nonempty,
  input  joy_frame_pkg::snapshot_t    head,
  output logic                        pop,
  output game_ctrl_pkg::game_inputs_t game_inputs,
  output logic                        game_reset,     // Arcade reset level
  output logic                        reboot_req      // One-cycle request
);

  joy_frame_pkg::snapshot_t held;        // Previous consumed snapshot
  joy_frame_pkg::snapshot_t src;         // Snapshot this tick maps from
  logic [1:0]               coin_fall;   // [1] pad B, [0] pad A
  logic [1:0]               start_fall;
  logic                     reboot_fall;

  assign pop = game_tick & fifo_nonempty;  // Take one entry per tick
  assign src = pop ? head : held;

  ////////////////////
  // Edge detect
  ////////////////////
  // High-to-low of an active-low button against the last consumed word
  always_comb begin
    coin_fall[0]  = pop & held.pad_a.coin_n  & ~head.pad_a.coin_n;
    coin_fall[1]  = pop & held.pad_b.coin_n  & ~head.pad_b.coin_n;
    start_fall[0] = pop & held.pad_a.start_n & ~head.pad_a.start_n;
    start_fall[1] = pop & held.pad_b.start_n & ~head.pad_b.start_n;
    reboot_fall   = pop & held.pad_b.reset_n & ~head.pad_b.reset_n;  // Pad B reset button
  end

  ////////////////////
  // Output registers
  ////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      held        <= '1;  // Idle pads, all released
      game_inputs <= '0;
      game_reset  <= 1'b0;
      reboot_req  <= 1'b0;
    end else begin
      reboot_req <= 1'b0;
      if (game_tick) begin
        held                   <= src;
        // Active low on the pads, active high for the game
        game_inputs.joystick_a <= ~src.pad_a.action[5:0];
        game_inputs.joystick_b <= ~src.pad_b.action[5:0];
        game_inputs.aux_a      <= ~src.pad_a.aux_a;
        game_inputs.aux_b      <= ~src.pad_b.aux_a;
        game_inputs.coin       <= coin_fall;   // One tick period, clears next tick
        game_inputs.start      <= start_fall;
        game_reset             <= ~src.pad_a.reset_n;  // Level, held while pressed
        reboot_req             <= reboot_fall;
      end
    end
  end

  // Reboot is a request, never a level
  a_reboot_pulse: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    reboot_req |=> !reboot_req);

endmodule

// File: src/joy_input_top.sv
module joy_input_top (
  input  logic                        ena_x,
  input  logic                        pll_lckd,
  input  logic                        joy_data,
  input  logic                        game_tick,
  output logic                        joy_load,
  output game_ctrl_pkg::game_inputs_t game_inputs,
  output logic                        game_reset,
  output logic                        reboot_req
);

  logic                     snap_valid;
  joy_frame_pkg::snapshot_t snap;
  logic                     credit_return;
  logic                     fifo_nonempty;
  joy_frame_pkg::snapshot_t head;
  logic                     pop;

  // Pads to snapshots, credit-limited
  joy_frame_reader joy_frame_reader_i (
    .ena_x         (ena_x),
    .pll_lckd      (pll_lckd),
    .joy_data      (joy_data),
    .joy_load      (joy_load),
    .credit_return (credit_return),
    .snap_valid    (snap_valid),
    .snap          (snap)
  );

  snapshot_fifo snapshot_fifo_i (
    .ena_x         (ena_x),
    .pll_lckd      (pll_lckd),
    .snap_valid    (snap_valid),
    .snap          (snap),
    .pop           (pop),
    .fifo_nonempty (fifo_nonempty),
    .head          (head),
    .credit_return (credit_return)
  );

  // Drained at the game's sample rate
  game_input_mapper game_input_mapper_i (
    .ena_x         (ena_x),
    .pll_lckd      (pll_lckd),
    .game_tick     (game_tick),
    .fifo_nonempty (fifo_nonempty),
    .head          (head),
    .pop           (pop),
    .game_inputs   (game_inputs),
    .game_reset    (game_reset),
    .reboot_req    (reboot_req)
  );

endmodule

// File: verification/joy_pad_model.sv
module joy_pad_model (
  input  logic                     ena_x,
  input  logic                     joy_load,      // Low at a rising edge loads both pads
  input  joy_frame_pkg::snapshot_t next_word,     // Buttons held at the next load
  output logic                     joy_data,      // Serial out of the chained pair
  output joy_frame_pkg::snapshot_t latched_word   // Word of the frame being shifted
);

  localparam int PAD_W = 12;  // Pad B sits in the low half

  // Pad bit order inside one pad, as the board wires the shift chain
  localparam int LOW_ORDER  [8] = '{8, 6, 5, 4, 3, 2, 1, 0};
  localparam int HIGH_ORDER [4] = '{10, 11, 9, 7};

  int slot;  // Slot of the current frame, 0 is the load slot

  ////////////////////
  // Slot order
  ////////////////////
  // Snapshot bit shifted in data slot k, k counted from the first sampled slot
  function automatic int snap_bit(input int k);
    if (k < 8) begin
      return PAD_W + LOW_ORDER[k];       // Pad A buttons and directions
    end else if (k < 16) begin
      return LOW_ORDER[k - 8];           // Pad B buttons and directions
    end else if (k < 20) begin
      return HIGH_ORDER[k - 16];         // Pad B aux, reset, coin
    end else begin
      return PAD_W + HIGH_ORDER[k - 20]; // Pad A aux, reset, coin
    end
  endfunction

  initial begin
    joy_data     = 1'b1;                      // Released line
    latched_word = '1;
    slot         = joy_frame_pkg::FRAME_SLOTS; // Nothing loaded yet
  end

  ////////////////////
  // Shift chain
  ////////////////////
  always @(posedge ena_x or negedge ena_x) begin
    if (ena_x) begin
      if (!joy_load) begin
        latched_word <= next_word;  // Parallel load of both pads
        slot         <= 0;
      end
    end else if (slot < joy_frame_pkg::FRAME_SLOTS) begin
      slot <= slot + 1;  // Falling edge opens the next slot
      if (slot + 1 >= joy_frame_pkg::FIRST_SAMPLE_SLOT &&
          slot + 1 < joy_frame_pkg::FRAME_SLOTS) begin
        joy_data <= latched_word[snap_bit(slot + 1 - joy_frame_pkg::FIRST_SAMPLE_SLOT)];
      end else begin
        joy_data <= 1'b1;  // Dead slot, line idles high
      end
    end
  end

endmodule

// File: verification/joy_input_tb.sv
module joy_input_tb;

  localparam int SEED        = 32'hbf02;
  localparam int RESET_CYC   = 4;
  localparam int TICK_SLOT   = 12;  // Previous frame reached the buffer head long before
  localparam int N_IDLE      = 3;
  localparam int N_DECODE    = 24;
  localparam int N_REPEAT    = 6;
  localparam int N_RESUME    = 3;   // Ticked frames after the repeats
  localparam int N_HOLD      = 10;  // Frames with ticks held off
  localparam int N_DRAIN     = 8;
  localparam int N_EDGE      = 8;
  localparam int N_FRAMES    = N_IDLE + N_DECODE + N_REPEAT + N_RESUME +
                               N_HOLD + N_DRAIN + N_EDGE;
  localparam int CYCLE_LIMIT = N_FRAMES * joy_frame_pkg::FRAME_SLOTS * 2;

  logic                        ena_x;
  logic                        pll_lckd;
  logic                        joy_data;
  logic                        game_tick;
  logic                        joy_load;
  game_ctrl_pkg::game_inputs_t game_inputs;
  logic                        game_reset;
  logic                        reboot_req;
  joy_frame_pkg::snapshot_t    next_word;
  joy_frame_pkg::snapshot_t    latched_word;

  // Reference side
  game_ctrl_pkg::game_inputs_t exp_inputs;
  logic                        exp_reset;
  logic                        exp_reboot;
  joy_frame_pkg::snapshot_t    exp_q [$];    // Snapshots expected in the buffer, oldest first
  joy_frame_pkg::snapshot_t    consumed;     // Last snapshot the mapper took
  joy_frame_pkg::snapshot_t    last_taken;   // Newest word past the change filter
  joy_frame_pkg::snapshot_t    pend_word;    // Waiting for a credit
  logic                        pend_valid;
  logic                        taken_any;
  logic                        have_frame;
  int                          err_cnt;
  int                          test_cnt;
  int                          loads_seen;
  int                          cycles;

  joy_input_top joy_input_top_i (
    .ena_x       (ena_x),
    .pll_lckd    (pll_lckd),
    .joy_data    (joy_data),
    .game_tick   (game_tick),
    .joy_load    (joy_load),
    .game_inputs (game_inputs),
    .game_reset  (game_reset),
    .reboot_req  (reboot_req)
  );

  joy_pad_model pad_model_i (
    .ena_x        (ena_x),
    .joy_load     (joy_load),
    .next_word    (next_word),
    .joy_data     (joy_data),
    .latched_word (latched_word)
  );

  initial begin
    ena_x = 1'b0;
    forever #4 ena_x = ~ena_x;
  end

  always @(negedge ena_x) begin
    if (pll_lckd && !joy_load) loads_seen++;  // Frames started since reset
  end

  ////////////////////
  // Checks
  ////////////////////
  a_reset_state: assert property (@(posedge ena_x)
    !pll_lckd |-> joy_load && game_inputs == '0 && !game_reset && !reboot_req)
    else report_err("outputs not idle during reset");

  a_inputs: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    game_inputs == exp_inputs)
    else report_err($sformatf("game_inputs %h, expected %h", game_inputs, exp_inputs));

  a_game_reset: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    game_reset == exp_reset)
    else report_err($sformatf("game_reset %b, expected %b", game_reset, exp_reset));

  a_reboot: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    reboot_req == exp_reboot)
    else report_err($sformatf("reboot_req %b, expected %b", reboot_req, exp_reboot));

  // Load low for slot 0 only, once every frame
  a_load_pulse: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    !joy_load |=> joy_load)
    else report_err("joy_load low for more than one cycle");

  a_frame_period: assert property (@(posedge ena_x) disable iff (!pll_lckd)
    (!joy_load && loads_seen > 1) |-> $past(!joy_load, joy_frame_pkg::FRAME_SLOTS))
    else report_err("joy_load period is not one frame");

  task automatic report_err(input string msg);
    $display("ERR %0t: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic finish_test(input string name, input int base);
    test_cnt++;
    $display("test %-12s %s, %0d errors", name, (err_cnt == base) ? "ok" : "failed",
             err_cnt - base);
  endtask

  // Active-high game view of a consumed snapshot, edges against the one before
  function automatic game_ctrl_pkg::game_inputs_t map_inputs(
      input joy_frame_pkg::snapshot_t s, input joy_frame_pkg::snapshot_t prev, input logic popped);
    game_ctrl_pkg::game_inputs_t g;
    g.joystick_a = ~s.pad_a.action[5:0];
    g.joystick_b = ~s.pad_b.action[5:0];
    g.aux_a      = ~s.pad_a.aux_a;
    g.aux_b      = ~s.pad_b.aux_a;  // Player 2 second button
    g.coin[0]    = popped & prev.pad_a.coin_n & ~s.pad_a.coin_n;
    g.coin[1]    = popped & prev.pad_b.coin_n & ~s.pad_b.coin_n;
    g.start[0]   = popped & prev.pad_a.start_n & ~s.pad_a.start_n;
    g.start[1]   = popped & prev.pad_b.start_n & ~s.pad_b.start_n;
    return g;
  endfunction

  ////////////////////
  // Expected flow
  ////////////////////
  // Finished frame passes the change filter, buffer or pending slot
  task automatic take_frame(input joy_frame_pkg::snapshot_t w);
    if (!taken_any || w != last_taken) begin
      taken_any  = 1'b1;
      last_taken = w;
      if (exp_q.size() < game_ctrl_pkg::FIFO_DEPTH) begin
        exp_q.push_back(w);
      end else begin
        pend_word  = w;  // Latest wins
        pend_valid = 1'b1;
      end
    end
  endtask

  task automatic tick();
    joy_frame_pkg::snapshot_t s;
    logic                     popped;
    game_tick = 1'b1;
    @(negedge ena_x);
    game_tick = 1'b0;
    popped    = (exp_q.size() != 0);
    if (popped) s = exp_q.pop_front();
    else s = consumed;  // Nothing new, mapper holds
    exp_inputs = map_inputs(s, consumed, popped);
    exp_reset  = ~s.pad_a.reset_n;
    exp_reboot = popped & consumed.pad_b.reset_n & ~s.pad_b.reset_n;
    consumed   = s;
    if (popped && pend_valid) begin
      exp_q.push_back(pend_word);  // Freed credit sends the pending word
      pend_valid = 1'b0;
    end
    @(negedge ena_x);
    exp_reboot = 1'b0;
  endtask

  // One frame of pad word w, with or without a game tick mid-frame
  task automatic run_frame(input joy_frame_pkg::snapshot_t w, input logic ticked);
    @(negedge ena_x);
    while (joy_load) @(negedge ena_x);  // Slot 0 of the next frame
    if (have_frame) take_frame(latched_word);  // Previous frame just ended
    have_frame = 1'b1;
    next_word  = w;
    if (ticked) begin
      repeat (TICK_SLOT) @(negedge ena_x);
      tick();
    end
  endtask

  initial begin
    joy_frame_pkg::snapshot_t w;
    int                       base;
    pll_lckd   = 1'b0;
    game_tick  = 1'b0;
    next_word  = '1;
    exp_inputs = '0;
    exp_reset  = 1'b0;
    exp_reboot = 1'b0;
    consumed   = '1;
    last_taken = '1;
    pend_word  = '1;
    pend_valid = 1'b0;
    taken_any  = 1'b0;
    have_frame = 1'b0;
    err_cnt    = 0;
    test_cnt   = 0;
    loads_seen = 0;
    void'($urandom(SEED));
    repeat (RESET_CYC) @(negedge ena_x);
    pll_lckd = 1'b1;

    base = err_cnt;  // Idle outputs until something is consumed
    repeat (N_IDLE) run_frame('1, 1'b0);
    finish_test("reset_state", base);

    base = err_cnt;
    for (int i = 0; i < N_DECODE; i++) begin
      w = 24'($urandom);
      run_frame(w, 1'b1);
    end
    finish_test("decode", base);

    base = err_cnt;
    w = '1;
    run_frame(w, 1'b1);  // Released first, so the press is a fresh edge
    w.pad_a.coin_n  = 1'b0;
    w.pad_b.start_n = 1'b0;
    repeat (N_REPEAT - 1) run_frame(w, 1'b0);  // Only one copy may reach the buffer
    w.pad_a.action[0] = 1'b0;
    repeat (N_RESUME) run_frame(w, 1'b1);  // A stored copy would delay the new word
    finish_test("change_filter", base);

    base = err_cnt;
    for (int i = 0; i < N_HOLD; i++) begin
      w = w ^ (24'($urandom) | 24'd1);  // Always a changed word
      run_frame(w, 1'b0);
    end
    repeat (N_DRAIN) run_frame(w, 1'b1);
    finish_test("backpressure", base);

    base = err_cnt;
    w = '1;
    run_frame(w, 1'b1);
    w.pad_a.coin_n = 1'b0;
    run_frame(w, 1'b1);  // Coin A press
    run_frame(w, 1'b1);  // Still held, pulse ends
    w = '1;
    w.pad_b.start_n = 1'b0;
    run_frame(w, 1'b1);
    w = '1;
    w.pad_a.reset_n = 1'b0;
    run_frame(w, 1'b1);  // Arcade reset level
    w = '1;
    w.pad_b.reset_n = 1'b0;
    run_frame(w, 1'b1);  // Reboot request
    w = '1;
    run_frame(w, 1'b1);
    run_frame(w, 1'b1);
    finish_test("edges", base);

    $display("%0d tests run, %0d errors", test_cnt, err_cnt);
    if (err_cnt == 0) $display("TESTS PASSED");
    else $display("TESTS FAILED");
    $finish;
  end

  // Run length bound
  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge ena_x);
      cycles++;
    end
    $display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: verilog.f
src/joy_frame_pkg.sv
src/game_ctrl_pkg.sv
src/joy_frame_reader.sv
src/snapshot_fifo.sv
src/game_input_mapper.sv
src/joy_input_top.sv
verification/joy_pad_model.sv
verification/joy_input_tb.sv

// File: Makefile
# Verilator flow for the joystick input front end
VERILATOR  ?= verilator
TOP        ?= joy_input_tb
RTL_TOP    ?= joy_input_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= TESTS PASSED
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
